// ==== src/ti_bus_pkg.sv ====
package ti_bus_pkg;

   // one cpu bus cycle, addr is a word address (a15 is not on this bus)
   typedef struct packed {
      logic        memen;
      logic        we;
      logic        dbin;
      logic [14:0] addr;
      logic [15:0] wdata;
   } cpu_req_t;

   typedef struct packed {
      logic [15:0] rdata;
      logic        ready;
   } cpu_rsp_t;

   typedef struct packed {
      logic        strobe;
      logic        we;
      logic [15:0] addr;   // byte address, bit 0 is a15
      logic [7:0]  wdata;
   } byte_req_t;

   typedef enum logic [1:0] {
      rgn_rom,
      rgn_cart,
      rgn_pad,
      rgn_open
   } region_e;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [15:0] paddr;
      logic [7:0]  pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [7:0] prdata;
      logic       pready;
      logic       pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic        strobe;
      logic        we;
      logic [13:0] addr;
      logic [7:0]  wdata;
   } host_byte_t;

   // cpu memory map, byte addresses
   localparam logic [15:0] rom_base  = 16'h0000;
   localparam int unsigned rom_win_bits = 13;  // 8 KB
   localparam logic [15:0] cart_base = 16'h6000;
   localparam int unsigned cart_win_bits = 13;
   localparam logic [15:0] pad_base  = 16'h8000;
   localparam int unsigned pad_win_bits = 10;  // 1 KB, ram repeats inside

   // host region codes in paddr[15:14]
   localparam logic [1:0] host_rgn_rom  = 2'd0;
   localparam logic [1:0] host_rgn_cart = 2'd1;
   localparam logic [1:0] host_rgn_pad  = 2'd2;
   localparam logic [1:0] host_rgn_open = 2'd3;

endpackage

// ==== src/address_decoder.sv ====
module address_decoder (
   input  ti_bus_pkg::cpu_req_t req_i,
   output ti_bus_pkg::region_e  region_o
);

   logic [15:0] byte_addr;
   logic        hit_rom;
   logic        hit_cart;
   logic        hit_pad;

   function automatic logic in_window(
      input logic [15:0] addr,
      input logic [15:0] base,
      input int unsigned bits
   );
      return (addr >> bits) == (base >> bits);
   endfunction

   assign byte_addr = {req_i.addr, 1'b0};

   assign hit_rom  = in_window(byte_addr, ti_bus_pkg::rom_base, ti_bus_pkg::rom_win_bits);
   assign hit_cart = in_window(byte_addr, ti_bus_pkg::cart_base, ti_bus_pkg::cart_win_bits);
   assign hit_pad  = in_window(byte_addr, ti_bus_pkg::pad_base, ti_bus_pkg::pad_win_bits);

   // anything outside the three windows reads as open bus
   // an unknown address leaves the region unknown
   assign region_o = hit_rom  ? ti_bus_pkg::rgn_rom  :
                     hit_cart ? ti_bus_pkg::rgn_cart :
                     hit_pad  ? ti_bus_pkg::rgn_pad  :
                                ti_bus_pkg::rgn_open;

   always_comb begin
      if (req_i.memen) begin
         a_region_known: assert final (!$isunknown(region_o))
            else $error("address decoder: region unknown during memory cycle");
      end
   end

endmodule

// ==== src/bus_multiplexer.sv ====
module bus_multiplexer (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  ti_bus_pkg::cpu_req_t  req_i,
   input  logic                  slow_i,
   output ti_bus_pkg::byte_req_t byte_o,
   input  logic [7:0]            byte_rdata_i,
   output logic [15:0]           rdata_o,
   output logic                  ready_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_high,
      st_low,
      st_done
   } state_e;

   state_e      state_q;
   logic        phase_q;  // second clock of a byte cycle
   logic [15:0] word_q;
   logic        busy;

   assign busy = (state_q == st_high) || (state_q == st_low);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= st_idle;
         phase_q <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (req_i.memen && slow_i) begin
                  state_q <= st_high;
               end
            end
            st_high: begin
               phase_q <= ~phase_q;
               if (phase_q) begin
                  state_q <= st_low;
               end
            end
            st_low: begin
               phase_q <= ~phase_q;
               if (phase_q) begin
                  state_q <= st_done;
               end
            end
            default: begin
               if (!req_i.memen) begin  // cpu saw ready and let go
                  state_q <= st_idle;
               end
            end
         endcase
      end
   end

   // byte data is back from the memory in the second clock
   always_ff @(posedge clk) begin
      if (phase_q && req_i.dbin) begin
         if (state_q == st_high) begin
            word_q[15:8] <= byte_rdata_i;
         end
         if (state_q == st_low) begin
            word_q[7:0] <= byte_rdata_i;
         end
      end
   end

   // even byte first, it is the high half of the word
   always_comb begin
      byte_o.strobe = busy && !phase_q;
      byte_o.we     = req_i.we;
      byte_o.addr   = {req_i.addr, state_q == st_low};
      byte_o.wdata  = (state_q == st_low) ? req_i.wdata[7:0] : req_i.wdata[15:8];
   end

   assign rdata_o = word_q;
   assign ready_o = (state_q == st_done);

   a_ready_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
      $rose(ready_o) |-> !byte_o.strobe &&
         $past(byte_o.strobe, 2) && $past(byte_o.strobe, 4))
      else $error("bus multiplexer: ready without two completed byte cycles");

   a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      busy |-> $stable(req_i))
      else $error("bus multiplexer: cpu request changed mid access");

endmodule

// ==== src/scratchpad_ram.sv ====
module scratchpad_ram (
   input  logic                   clk,
   input  logic                   cpu_cs_i,
   input  ti_bus_pkg::cpu_req_t   req_i,
   output logic [15:0]            rdata_o,
   input  ti_bus_pkg::host_byte_t host_i,
   output logic [7:0]             host_rdata_o
);

   logic [15:0] mem [128];
   logic [6:0]  cpu_idx;
   logic [6:0]  host_idx;

   // upper address bits are dropped, which gives the 256 byte mirrors
   assign cpu_idx  = req_i.addr[6:0];
   assign host_idx = host_i.addr[7:1];

   always_ff @(posedge clk) begin
      if (cpu_cs_i && req_i.we) begin
         mem[cpu_idx] <= req_i.wdata;
      end
      if (host_i.strobe && host_i.we) begin
         if (host_i.addr[0]) begin
            mem[host_idx][7:0] <= host_i.wdata;
         end else begin
            mem[host_idx][15:8] <= host_i.wdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cpu_cs_i && req_i.dbin) begin
         rdata_o <= mem[cpu_idx];
      end
      if (host_i.strobe && !host_i.we) begin
         host_rdata_o <= host_i.addr[0] ? mem[host_idx][7:0] : mem[host_idx][15:8];
      end
   end

endmodule

// ==== src/console_rom.sv ====
module console_rom #(
   parameter int unsigned rom_addr_bits = 12  // word address bits
) (
   input  logic                   clk,
   input  logic                   cpu_cs_i,
   input  ti_bus_pkg::cpu_req_t   req_i,
   output logic [15:0]            rdata_o,
   input  ti_bus_pkg::host_byte_t host_i,
   output logic [7:0]             host_rdata_o
);

   logic [15:0]              mem [2**rom_addr_bits];
   logic [rom_addr_bits-1:0] cpu_idx;
   logic [rom_addr_bits-1:0] host_idx;
   logic                     host_lo;

   assign cpu_idx  = req_i.addr[rom_addr_bits-1:0];
   assign host_idx = host_i.addr[rom_addr_bits:1];
   assign host_lo  = host_i.addr[0];  // odd byte is the low half

   // only the host loads the image, cpu writes go nowhere
   always_ff @(posedge clk) begin
      if (host_i.strobe && host_i.we) begin
         if (host_lo) begin
            mem[host_idx][7:0] <= host_i.wdata;
         end else begin
            mem[host_idx][15:8] <= host_i.wdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cpu_cs_i && req_i.dbin) begin
         rdata_o <= mem[cpu_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (host_i.strobe && !host_i.we) begin
         host_rdata_o <= host_lo ? mem[host_idx][7:0] : mem[host_idx][15:8];
      end
   end

endmodule

// ==== src/cartridge_rom.sv ====
module cartridge_rom #(
   parameter int unsigned cart_addr_bits = 14  // 16 KB, two banks
) (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  ti_bus_pkg::byte_req_t  byte_i,
   input  logic                   cart_cs_i,
   output logic [7:0]             rdata_o,
   input  ti_bus_pkg::host_byte_t host_i,
   output logic [7:0]             host_rdata_o
);

   localparam int unsigned win_bits  = ti_bus_pkg::cart_win_bits;
   localparam int unsigned bank_bits = cart_addr_bits - win_bits;

   logic [7:0]                mem [2**cart_addr_bits];
   logic [bank_bits-1:0]      bank_q;
   logic [cart_addr_bits-1:0] cpu_idx;
   logic [cart_addr_bits-1:0] host_idx;

   assign cpu_idx  = {bank_q, byte_i.addr[win_bits-1:0]};
   assign host_idx = host_i.addr[cart_addr_bits-1:0];  // linear, no banking

   // a write into the window only picks the bank, the rom is untouched
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bank_q <= '0;
      end else if (cart_cs_i && byte_i.strobe && byte_i.we) begin
         bank_q <= bank_bits'(byte_i.addr[1]);
      end
   end

   always_ff @(posedge clk) begin
      if (cart_cs_i && byte_i.strobe && !byte_i.we) begin
         rdata_o <= mem[cpu_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (host_i.strobe) begin
         if (host_i.we) begin
            mem[host_idx] <= host_i.wdata;
         end else begin
            host_rdata_o <= mem[host_idx];
         end
      end
   end

endmodule

// ==== src/host_port.sv ====
module host_port (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  ti_bus_pkg::apb_req_t   apb_i,
   output ti_bus_pkg::apb_rsp_t   apb_o,
   output ti_bus_pkg::host_byte_t rom_o,
   output ti_bus_pkg::host_byte_t cart_o,
   output ti_bus_pkg::host_byte_t pad_o,
   input  logic [7:0]             rom_rdata_i,
   input  logic [7:0]             cart_rdata_i,
   input  logic [7:0]             pad_rdata_i
);

   logic                   wait_q;  // set in the second access cycle
   logic                   access_first;
   logic [1:0]             target;
   ti_bus_pkg::host_byte_t cmd;

   assign target       = apb_i.paddr[15:14];
   assign access_first = apb_i.psel && apb_i.penable && !wait_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wait_q <= 1'b0;
      end else begin
         wait_q <= access_first;
      end
   end

   assign cmd.strobe = access_first;
   assign cmd.we     = apb_i.pwrite;
   assign cmd.addr   = apb_i.paddr[13:0];
   assign cmd.wdata  = apb_i.pwdata;

   always_comb begin
      rom_o         = cmd;
      rom_o.strobe  = access_first && (target == ti_bus_pkg::host_rgn_rom);
      cart_o        = cmd;
      cart_o.strobe = access_first && (target == ti_bus_pkg::host_rgn_cart);
      pad_o         = cmd;
      pad_o.strobe  = access_first && (target == ti_bus_pkg::host_rgn_pad);
   end

   // memories answer one clock after the strobe, right as pready goes up
   always_comb begin
      apb_o.pready  = wait_q;
      apb_o.pslverr = wait_q && (target == ti_bus_pkg::host_rgn_open);
      case (target)
         ti_bus_pkg::host_rgn_rom:  apb_o.prdata = rom_rdata_i;
         ti_bus_pkg::host_rgn_cart: apb_o.prdata = cart_rdata_i;
         ti_bus_pkg::host_rgn_pad:  apb_o.prdata = pad_rdata_i;
         default:                   apb_o.prdata = 8'h00;
      endcase
   end

   a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n_i)
      apb_i.penable |-> apb_i.psel)
      else $error("host port: penable without psel");

endmodule

// ==== src/mainboard.sv ====
module mainboard #(
   parameter int unsigned rom_addr_bits  = 12,
   parameter int unsigned cart_addr_bits = 14
) (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  ti_bus_pkg::cpu_req_t cpu_req_i,
   output ti_bus_pkg::cpu_rsp_t cpu_rsp_o,
   input  ti_bus_pkg::apb_req_t apb_i,
   output ti_bus_pkg::apb_rsp_t apb_o
);

   ti_bus_pkg::region_e    region;
   ti_bus_pkg::byte_req_t  byte_req;
   ti_bus_pkg::host_byte_t host_rom;
   ti_bus_pkg::host_byte_t host_cart;
   ti_bus_pkg::host_byte_t host_pad;

   logic        rom_cs;
   logic        pad_cs;
   logic        cart_cs;
   logic        slow;
   logic [15:0] rom_rdata;
   logic [15:0] pad_rdata;
   logic [15:0] mux_rdata;
   logic        mux_ready;
   logic [7:0]  byte_rdata;
   logic [7:0]  cart_rdata;
   logic [7:0]  rom_host_rdata;
   logic [7:0]  cart_host_rdata;
   logic [7:0]  pad_host_rdata;
   logic        fast_rdy_q;
   logic        rom_valid_q;
   logic        pad_valid_q;

   assign rom_cs  = cpu_req_i.memen && (region == ti_bus_pkg::rgn_rom);
   assign pad_cs  = cpu_req_i.memen && (region == ti_bus_pkg::rgn_pad);
   assign cart_cs = (region == ti_bus_pkg::rgn_cart);
   assign slow    = (region == ti_bus_pkg::rgn_cart) || (region == ti_bus_pkg::rgn_open);

   assign byte_rdata = cart_cs ? cart_rdata : 8'hff;  // open bus floats high

   // fast memories answer in one clock
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fast_rdy_q  <= 1'b0;
         rom_valid_q <= 1'b0;
         pad_valid_q <= 1'b0;
      end else begin
         fast_rdy_q  <= rom_cs || pad_cs;
         rom_valid_q <= rom_cs && cpu_req_i.dbin;
         pad_valid_q <= pad_cs && cpu_req_i.dbin;
      end
   end

   always_comb begin
      if (rom_valid_q) begin
         cpu_rsp_o.rdata = rom_rdata;
      end else if (pad_valid_q) begin
         cpu_rsp_o.rdata = pad_rdata;
      end else begin
         cpu_rsp_o.rdata = mux_rdata;
      end
      cpu_rsp_o.ready = cpu_req_i.memen && (fast_rdy_q || mux_ready);
   end

   address_decoder u_decoder (.req_i(cpu_req_i), .region_o(region));

   bus_multiplexer u_mux (
      .clk(clk), .arst_n_i(arst_n_i), .req_i(cpu_req_i), .slow_i(slow),
      .byte_o(byte_req), .byte_rdata_i(byte_rdata),
      .rdata_o(mux_rdata), .ready_o(mux_ready)
   );

   scratchpad_ram u_pad (
      .clk(clk), .cpu_cs_i(pad_cs), .req_i(cpu_req_i), .rdata_o(pad_rdata),
      .host_i(host_pad), .host_rdata_o(pad_host_rdata)
   );

   console_rom #(.rom_addr_bits(rom_addr_bits)) u_rom (
      .clk(clk), .cpu_cs_i(rom_cs), .req_i(cpu_req_i), .rdata_o(rom_rdata),
      .host_i(host_rom), .host_rdata_o(rom_host_rdata)
   );

   cartridge_rom #(.cart_addr_bits(cart_addr_bits)) u_cart (
      .clk(clk), .arst_n_i(arst_n_i), .byte_i(byte_req), .cart_cs_i(cart_cs),
      .rdata_o(cart_rdata), .host_i(host_cart), .host_rdata_o(cart_host_rdata)
   );

   host_port u_host (
      .clk(clk), .arst_n_i(arst_n_i), .apb_i(apb_i), .apb_o(apb_o),
      .rom_o(host_rom), .cart_o(host_cart), .pad_o(host_pad),
      .rom_rdata_i(rom_host_rdata), .cart_rdata_i(cart_host_rdata),
      .pad_rdata_i(pad_host_rdata)
   );

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
   parameter int period       = 100,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic arst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      arst_n_o <= 1'b1;
   end

endmodule

// ==== verif/tb_mainboard.sv ====
module tb_mainboard;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int rom_addr_bits  = 12;
   localparam int cart_addr_bits = 14;
   localparam int rom_bytes   = 2 ** (rom_addr_bits + 1);
   localparam int cart_bytes  = 2 ** cart_addr_bits;
   localparam int bank_bytes  = 8192;
   localparam int pad_bytes   = 256;
   localparam int clk_period  = 100;
   localparam int max_wait    = 16;
   localparam int n_samples   = 8;
   localparam int fast_cycles = 1;
   localparam int slow_cycles = 5;  // two byte cycles of two clocks, then done
   // host transfers take four clocks each, cpu accesses at most eight
   localparam int host_xfers  = 2 * (rom_bytes + cart_bytes + pad_bytes) + 64;
   localparam int run_cycles  = host_xfers * 4 + 128 * 8 + 1000;

   logic clk;
   logic clk_rst_n;
   logic soft_rst_n;
   logic arst_n;
   ti_bus_pkg::cpu_req_t cpu_req;
   ti_bus_pkg::cpu_rsp_t cpu_rsp;
   ti_bus_pkg::apb_req_t apb_req;
   ti_bus_pkg::apb_rsp_t apb_rsp;

   logic [7:0]  rom_img  [rom_bytes];
   logic [7:0]  cart_img [cart_bytes];
   logic [7:0]  pad_img  [pad_bytes];
   int          errors;
   int          checks;
   int unsigned seed;

   assign arst_n = clk_rst_n && soft_rst_n;

   tb_clock #(.period(clk_period), .reset_cycles(4)) u_clock (.clk(clk), .arst_n_o(clk_rst_n));

   mainboard #(.rom_addr_bits(rom_addr_bits), .cart_addr_bits(cart_addr_bits)) UUT (
      .clk(clk), .arst_n_i(arst_n), .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
      .apb_i(apb_req), .apb_o(apb_rsp)
   );

   task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_cycles(input string name, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("ERROR %s: expected %0d clocks, actual %0d clocks", name, exp, act);
      end
   endtask

   function automatic logic [15:0] host_addr(input logic [1:0] rgn, input int offs);
      return {rgn, 14'(offs)};  // region code sits in the top two bits
   endfunction

   function automatic logic [15:0] cart_word(input int bank, input int offs);
      return {cart_img[bank * bank_bytes + offs], cart_img[bank * bank_bytes + offs + 1]};
   endfunction

   task automatic cpu_access(
      input  string       name,
      input  logic        wr,
      input  logic [15:0] addr,
      input  logic [15:0] wdata,
      output logic [15:0] rdata,
      output int          cycles
   );
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      @(posedge clk);
      cpu_req.memen <= 1'b1;
      cpu_req.we    <= wr;
      cpu_req.dbin  <= !wr;
      cpu_req.addr  <= addr[15:1];
      cpu_req.wdata <= wdata;
      while (!seen && cycles < max_wait) begin
         @(negedge clk);
         seen = cpu_rsp.ready;
         if (!seen) begin
            cycles++;
         end
      end
      if (!seen) begin
         errors++;
         $display("%s: no ready on the CPU bus within %0d clocks", name, max_wait);
      end
      rdata = cpu_rsp.rdata;
      @(posedge clk);  // cpu lets go after ready
      cpu_req.memen <= 1'b0;
      cpu_req.we    <= 1'b0;
      cpu_req.dbin  <= 1'b0;
   endtask

   task automatic cpu_read(
      input string       name,
      input logic [15:0] addr,
      input logic [15:0] exp,
      input int          exp_cycles
   );
      logic [15:0] rdata;
      int          cycles;
      cpu_access(name, 1'b0, addr, 16'h0000, rdata, cycles);
      check_word(name, exp, rdata);
      check_cycles(name, exp_cycles, cycles);
   endtask

   task automatic cpu_write(
      input string       name,
      input logic [15:0] addr,
      input logic [15:0] wdata,
      input int          exp_cycles
   );
      logic [15:0] rdata;
      int          cycles;
      cpu_access(name, 1'b1, addr, wdata, rdata, cycles);
      check_cycles(name, exp_cycles, cycles);
   endtask

   task automatic apb_xfer(
      input  string       name,
      input  logic        wr,
      input  logic [15:0] addr,
      input  logic [7:0]  wdata,
      output logic [7:0]  rdata,
      output logic        err,
      output int          waits
   );
      logic seen;
      seen  = 1'b0;
      waits = 0;
      @(posedge clk);
      apb_req.psel    <= 1'b1;  // setup phase
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      while (!seen && waits < max_wait) begin
         @(negedge clk);
         seen = apb_rsp.pready;
         if (!seen) begin
            waits++;
         end
      end
      if (!seen) begin
         errors++;
         $display("%s: no pready from the host port within %0d clocks", name, max_wait);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic host_read(
      input string       name,
      input logic [15:0] addr,
      input logic [7:0]  exp,
      input logic        exp_err
   );
      logic [7:0] rdata;
      logic       err;
      int         waits;
      apb_xfer(name, 1'b0, addr, 8'h00, rdata, err, waits);
      check_byte(name, exp, rdata);
      check_err(name, exp_err, err);
      check_cycles(name, 1, waits);
   endtask

   task automatic host_write(
      input string       name,
      input logic [15:0] addr,
      input logic [7:0]  wdata,
      input logic        exp_err
   );
      logic [7:0] rdata;
      logic       err;
      int         waits;
      apb_xfer(name, 1'b1, addr, wdata, rdata, err, waits);
      check_err(name, exp_err, err);
      check_cycles(name, 1, waits);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      soft_rst_n <= 1'b0;
      repeat (4) @(posedge clk);
      soft_rst_n <= 1'b1;
      @(negedge clk);
      check_err("ready after reset", 1'b0, cpu_rsp.ready);
      check_err("pready after reset", 1'b0, apb_rsp.pready);
      check_err("pslverr after reset", 1'b0, apb_rsp.pslverr);
   endtask

   task automatic host_load_test();
      for (int i = 0; i < rom_bytes; i++) begin
         rom_img[i] = 8'($urandom);
         host_write($sformatf("rom load %h", i), host_addr(2'd0, i), rom_img[i], 1'b0);
      end
      for (int i = 0; i < cart_bytes; i++) begin
         cart_img[i] = 8'($urandom);
         host_write($sformatf("cart load %h", i), host_addr(2'd1, i), cart_img[i], 1'b0);
      end
      for (int i = 0; i < pad_bytes; i++) begin
         pad_img[i] = 8'($urandom);
         host_write($sformatf("pad load %h", i), host_addr(2'd2, i), pad_img[i], 1'b0);
      end
      for (int i = 0; i < rom_bytes; i++) begin
         host_read($sformatf("rom readback %h", i), host_addr(2'd0, i), rom_img[i], 1'b0);
      end
      for (int i = 0; i < cart_bytes; i++) begin
         host_read($sformatf("cart readback %h", i), host_addr(2'd1, i), cart_img[i], 1'b0);
      end
      for (int i = 0; i < pad_bytes; i++) begin
         host_read($sformatf("pad readback %h", i), host_addr(2'd2, i), pad_img[i], 1'b0);
      end
      host_write("unmapped host write", 16'hc123, 8'h5a, 1'b1);
      host_read("unmapped host read", 16'hc123, 8'h00, 1'b1);
   endtask

   task automatic rom_test();
      int offs;
      for (int n = 0; n < n_samples; n++) begin
         offs = 2 * ($urandom % (rom_bytes / 2));
         cpu_read($sformatf("rom read %h", offs), 16'(offs),
                  {rom_img[offs], rom_img[offs + 1]}, fast_cycles);
      end
      offs = 16'h0100;
      cpu_write("rom write", 16'(offs), ~{rom_img[offs], rom_img[offs + 1]}, fast_cycles);
      cpu_read("rom read after write", 16'(offs), {rom_img[offs], rom_img[offs + 1]},
               fast_cycles);
      host_read("rom host high after write", host_addr(2'd0, offs), rom_img[offs], 1'b0);
      host_read("rom host low after write", host_addr(2'd0, offs + 1), rom_img[offs + 1], 1'b0);
   endtask

   task automatic pad_test();
      int          offs;
      logic [15:0] wdata;
      for (int n = 0; n < n_samples; n++) begin
         offs  = 2 * ($urandom % (pad_bytes / 2));
         wdata = 16'($urandom);
         pad_img[offs]     = wdata[15:8];
         pad_img[offs + 1] = wdata[7:0];
         cpu_write($sformatf("pad write %h", offs), 16'h8000 + 16'(offs), wdata, fast_cycles);
         cpu_read($sformatf("pad read %h", offs), 16'h8000 + 16'(offs), wdata, fast_cycles);
         cpu_read($sformatf("pad mirror %h", offs), 16'h8100 + 16'(offs), wdata, fast_cycles);
         host_read("pad host high", host_addr(2'd2, offs), pad_img[offs], 1'b0);
         host_read("pad host low", host_addr(2'd2, offs + 1), pad_img[offs + 1], 1'b0);
      end
   endtask

   task automatic bank_reads(input string name, input int bank);
      int offs;
      for (int n = 0; n < n_samples; n++) begin
         offs = 2 * ($urandom % (bank_bytes / 2));
         cpu_read($sformatf("%s %h", name, offs), 16'h6000 + 16'(offs),
                  cart_word(bank, offs), slow_cycles);
      end
   endtask

   task automatic cart_test();
      bank_reads("cart bank 0", 0);
   endtask

   task automatic bank_test();
      cpu_write("select bank 1", 16'h6002, 16'h0000, slow_cycles);
      bank_reads("bank 1", 1);
      cpu_write("select bank 0", 16'h6000, 16'h0000, slow_cycles);
      bank_reads("bank 0", 0);
      cpu_write("select bank 1 again", 16'h6002, 16'h0000, slow_cycles);
      apply_reset();
      bank_reads("bank after reset", 0);
   endtask

   task automatic open_test();
      cpu_read("open bus 4000", 16'h4000, 16'hffff, slow_cycles);
      cpu_read("open bus 8400", 16'h8400, 16'hffff, slow_cycles);  // just above the pad window
   endtask

   initial begin
      cpu_req    = '0;
      apb_req    = '0;
      soft_rst_n = 1'b1;
      errors     = 0;
      checks     = 0;
      seed       = 32'h9768;
      void'($urandom(seed));
      wait (arst_n === 1'b1);
      @(negedge clk);
      check_err("ready after power-on reset", 1'b0, cpu_rsp.ready);
      check_err("pready after power-on reset", 1'b0, apb_rsp.pready);
      check_err("pslverr after power-on reset", 1'b0, apb_rsp.pslverr);
      host_load_test();
      rom_test();
      pad_test();
      cart_test();
      bank_test();
      open_test();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      #(run_cycles * clk_period);
      $display("watchdog: tests did not finish within %0d clocks", run_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== sources.f ====
src/ti_bus_pkg.sv
src/address_decoder.sv
src/bus_multiplexer.sv
src/scratchpad_ram.sv
src/console_rom.sv
src/cartridge_rom.sv
src/host_port.sv
src/mainboard.sv
verif/tb_clock.sv
verif/tb_mainboard.sv
